/* hdl/ex_me_if.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

// one instruction leaving the EX/ME register
interface ex_me_if;
	logic                  valid;
	mips_pkg::ctrl_t       ctrl;
	logic [`MIPS_XLEN-1:0] result;	// alu sum/difference or memory address
	logic [`MIPS_XLEN-1:0] store_data;	// forwarded rt for sw

	// execute owns the register
	modport ex (
		output valid,
		output ctrl,
		output result,
		output store_data
	);

	// memory stage only looks
	modport me (
		input valid,
		input ctrl,
		input result,
		input store_data
	);
endinterface

/* hdl/execute.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module execute (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  id_valid,
	input  mips_pkg::ctrl_t       id_ctrl,
	input  logic [4:0]            id_rs_sel,
	input  logic [4:0]            id_rt_sel,
	input  logic [`MIPS_XLEN-1:0] id_rs_val,
	input  logic [`MIPS_XLEN-1:0] id_rt_val,
	input  logic [15:0]           id_imm,
	input  logic                  wb_en,	// already excludes r0
	input  logic [4:0]            wb_sel,
	input  logic [`MIPS_XLEN-1:0] wb_data,
	ex_me_if.ex                   ex_me
);
	logic                  me_fwd;	// EX/ME result usable for forwarding
	logic [`MIPS_XLEN-1:0] op_a;	// rs after forwarding
	logic [`MIPS_XLEN-1:0] op_b;	// rt after forwarding
	logic [`MIPS_XLEN-1:0] imm_ext;
	logic [`MIPS_XLEN-1:0] alu_out;

	// newest producer wins, then write-back, then the regfile value
	function automatic logic [`MIPS_XLEN-1:0] pick_operand(
		input logic [4:0]            sel,
		input logic [`MIPS_XLEN-1:0] id_val,
		input logic                  me_ok,
		input logic [4:0]            me_dest,
		input logic [`MIPS_XLEN-1:0] me_val,
		input logic                  wb_ok,
		input logic [4:0]            wb_dest,
		input logic [`MIPS_XLEN-1:0] wb_val
	);
		if (me_ok && me_dest == sel)
			return me_val;
		else if (wb_ok && wb_dest == sel)
			return wb_val;
		return id_val;
	endfunction

	// a load in EX/ME has no data yet, the stall keeps it from being needed
	assign me_fwd = ex_me.valid && ex_me.ctrl.wb_en && !ex_me.ctrl.mem_rd &&
	                (ex_me.ctrl.dest != 5'd0);

	assign op_a = pick_operand(id_rs_sel, id_rs_val, me_fwd, ex_me.ctrl.dest, ex_me.result,
	                           wb_en, wb_sel, wb_data);
	assign op_b = pick_operand(id_rt_sel, id_rt_val, me_fwd, ex_me.ctrl.dest, ex_me.result,
	                           wb_en, wb_sel, wb_data);

	assign imm_ext = {{(`MIPS_XLEN-16){id_imm[15]}}, id_imm};	// sign extend

	always_comb begin
		case (id_ctrl.alu_op)
			mips_pkg::SUB_RT:  alu_out = op_a - op_b;
			mips_pkg::ADD_IMM: alu_out = op_a + imm_ext;	// addiu, lw/sw address
			default:           alu_out = op_a + op_b;	// addu
		endcase
	end

	// EX/ME
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_me.valid <= 1'b0;
			ex_me.ctrl  <= '0;
		end else begin
			ex_me.valid <= id_valid;
			ex_me.ctrl  <= id_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		ex_me.result     <= alu_out;
		ex_me.store_data <= op_b;	// forwarded rt
	end

endmodule

/* hdl/fetch_decode.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module fetch_decode (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`MIPS_XLEN-1:0] instr_in,
	output logic [`MIPS_XLEN-1:0] instr_addr,
	output logic [4:0]            rs_sel,	// to regfile, from IF/ID
	output logic [4:0]            rt_sel,
	input  logic [`MIPS_XLEN-1:0] rs_data,
	input  logic [`MIPS_XLEN-1:0] rt_data,
	output logic                  id_valid,
	output mips_pkg::ctrl_t       id_ctrl,
	output logic [4:0]            id_rs_sel,
	output logic [4:0]            id_rt_sel,
	output logic [`MIPS_XLEN-1:0] id_rs_val,
	output logic [`MIPS_XLEN-1:0] id_rt_val,
	output logic [15:0]           id_imm
);
	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] if_instr;	// IF/ID
	logic                  if_valid;
	mips_pkg::opcode_e     opcode;
	mips_pkg::funct_e      funct;
	mips_pkg::ctrl_t       dec_ctrl;
	logic                  uses_rt;	// rt is a source, not the dest
	logic                  stall;	// load-use

	assign instr_addr = pc;

	// fetch, no branches so the pc only ever steps by 4
	always_ff @(posedge clk) begin
		if (reset) begin
			pc       <= `MIPS_PC_INIT;
			if_valid <= 1'b0;
		end else if (!stall) begin
			pc       <= pc + `MIPS_XLEN'(4);
			if_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
		if (!stall)
			if_instr <= instr_in;	// frozen together with the pc

	assign opcode = mips_pkg::opcode_e'(if_instr[31:26]);
	assign funct  = mips_pkg::funct_e'(if_instr[5:0]);
	assign rs_sel = if_instr[25:21];
	assign rt_sel = if_instr[20:16];

	// decode, anything unknown falls out as a nop
	always_comb begin
		dec_ctrl.alu_op = mips_pkg::ADD_RT;
		dec_ctrl.mem_rd = 1'b0;
		dec_ctrl.mem_wr = 1'b0;
		dec_ctrl.wb_en  = 1'b0;
		dec_ctrl.dest   = 5'd0;
		uses_rt         = 1'b0;
		case (opcode)
			mips_pkg::SPECIAL: begin
				case (funct)
					mips_pkg::ADDU, mips_pkg::SUBU: begin
						dec_ctrl.alu_op = (funct == mips_pkg::SUBU) ? mips_pkg::SUB_RT
						                                              : mips_pkg::ADD_RT;
						dec_ctrl.wb_en  = 1'b1;
						dec_ctrl.dest   = if_instr[15:11];	// rd
						uses_rt         = 1'b1;
					end
					default: ;	// sll, shift amount ignored
				endcase
			end
			mips_pkg::ADDIU: begin
				dec_ctrl.alu_op = mips_pkg::ADD_IMM;
				dec_ctrl.wb_en  = 1'b1;
				dec_ctrl.dest   = if_instr[20:16];	// rt
			end
			mips_pkg::LW: begin
				dec_ctrl.alu_op = mips_pkg::ADD_IMM;	// base + offset
				dec_ctrl.mem_rd = 1'b1;
				dec_ctrl.wb_en  = 1'b1;
				dec_ctrl.dest   = if_instr[20:16];
			end
			mips_pkg::SW: begin
				dec_ctrl.alu_op = mips_pkg::ADD_IMM;
				dec_ctrl.mem_wr = 1'b1;
				uses_rt         = 1'b1;	// store data
			end
			default: ;
		endcase
	end

	// load in EX whose dest is read by the instruction behind it
	assign stall = if_valid && id_valid && id_ctrl.mem_rd && (id_ctrl.dest != 5'd0) &&
	               ((id_ctrl.dest == rs_sel) || (uses_rt && id_ctrl.dest == rt_sel));

	// ID/EX
	always_ff @(posedge clk) begin
		if (reset) begin
			id_valid <= 1'b0;
			id_ctrl  <= '0;
		end else begin
			id_valid <= if_valid && !stall;	// bubble on stall
			id_ctrl  <= dec_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		id_rs_sel <= rs_sel;
		id_rt_sel <= rt_sel;
		id_rs_val <= rs_data;
		id_rt_val <= rt_data;
		id_imm    <= if_instr[15:0];
	end

endmodule

/* hdl/mem_writeback.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mem_writeback (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`MIPS_XLEN-1:0] data_in,
	ex_me_if.me                   ex_me,
	output logic [`MIPS_XLEN-1:0] data_addr,
	output logic [`MIPS_XLEN-1:0] data_out,
	output logic                  data_rd_wr,	// low = write
	output logic                  wb_en,
	output logic [4:0]            wb_sel,
	output logic [`MIPS_XLEN-1:0] wb_data
);
	logic                  wb_valid;	// ME/WB write enable
	logic [4:0]            wb_dest;
	logic [`MIPS_XLEN-1:0] wb_value;

	// data bus straight from EX/ME
	assign data_addr  = ex_me.result;
	assign data_out   = ex_me.store_data;
	assign data_rd_wr = !(ex_me.valid && ex_me.ctrl.mem_wr);	// one low cycle per sw

	// ME/WB, r0 writes dropped here so forwarding never sees them
	always_ff @(posedge clk) begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_me.valid && ex_me.ctrl.wb_en && (ex_me.ctrl.dest != 5'd0);
	end

	always_ff @(posedge clk) begin
		wb_dest  <= ex_me.ctrl.dest;
		wb_value <= ex_me.ctrl.mem_rd ? data_in : ex_me.result;	// load data or alu
	end

	// register write happens at the next edge in the regfile
	assign wb_en   = wb_valid;
	assign wb_sel  = wb_dest;
	assign wb_data = wb_value;

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_core (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`MIPS_XLEN-1:0] instr_in,
	input  logic [`MIPS_XLEN-1:0] data_in,
	output logic [`MIPS_XLEN-1:0] instr_addr,
	output logic [`MIPS_XLEN-1:0] data_addr,
	output logic [`MIPS_XLEN-1:0] data_out,
	output logic                  data_rd_wr
);
	logic [4:0]            rs_sel, rt_sel;	// decode read ports
	logic [`MIPS_XLEN-1:0] rs_data, rt_data;
	logic                  id_valid;	// ID/EX bundle
	mips_pkg::ctrl_t       id_ctrl;
	logic [4:0]            id_rs_sel, id_rt_sel;
	logic [`MIPS_XLEN-1:0] id_rs_val, id_rt_val;
	logic [15:0]           id_imm;
	logic                  wb_en;	// write-back port
	logic [4:0]            wb_sel;
	logic [`MIPS_XLEN-1:0] wb_data;

	ex_me_if ex_me ();

	regfile regfile_inst (
		.clk(clk), .reset(reset),
		.rd0_sel(rs_sel), .rd1_sel(rt_sel),
		.wr_en(wb_en), .wr_sel(wb_sel), .wr_data(wb_data),
		.rd0_data(rs_data), .rd1_data(rt_data)
	);

	fetch_decode fetch_decode_inst (
		.clk(clk), .reset(reset), .instr_in(instr_in), .instr_addr(instr_addr),
		.rs_sel(rs_sel), .rt_sel(rt_sel), .rs_data(rs_data), .rt_data(rt_data),
		.id_valid(id_valid), .id_ctrl(id_ctrl), .id_rs_sel(id_rs_sel), .id_rt_sel(id_rt_sel),
		.id_rs_val(id_rs_val), .id_rt_val(id_rt_val), .id_imm(id_imm)
	);

	execute execute_inst (
		.clk(clk), .reset(reset),
		.id_valid(id_valid), .id_ctrl(id_ctrl), .id_rs_sel(id_rs_sel), .id_rt_sel(id_rt_sel),
		.id_rs_val(id_rs_val), .id_rt_val(id_rt_val), .id_imm(id_imm),
		.wb_en(wb_en), .wb_sel(wb_sel), .wb_data(wb_data),
		.ex_me(ex_me.ex)
	);

	mem_writeback mem_writeback_inst (
		.clk(clk), .reset(reset), .data_in(data_in), .ex_me(ex_me.me),
		.data_addr(data_addr), .data_out(data_out), .data_rd_wr(data_rd_wr),
		.wb_en(wb_en), .wb_sel(wb_sel), .wb_data(wb_data)
	);

endmodule

/* hdl/mips_pkg.sv */
package mips_pkg;

	// major opcode field, instr[31:26]
	typedef enum logic [5:0] {
		SPECIAL = 6'h00,	// r-type, look at funct
		ADDIU   = 6'h09,
		LW      = 6'h23,
		SW      = 6'h2b
	} opcode_e;

	// funct field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		SLL  = 6'h00,	// only the all-zero nop form
		ADDU = 6'h21,
		SUBU = 6'h23
	} funct_e;

	// what the execute stage computes
	typedef enum logic [1:0] {
		ADD_RT  = 2'd0,	// rs + rt
		SUB_RT  = 2'd1,	// rs - rt
		ADD_IMM = 2'd2	// rs + sext(imm), also load/store address
	} alu_op_e;

	// decoded control, follows the instruction down the pipe
	typedef struct packed {
		alu_op_e    alu_op;
		logic       mem_rd;	// lw
		logic       mem_wr;	// sw
		logic       wb_en;	// writes a register
		logic [4:0] dest;	// rd or rt
	} ctrl_t;

endpackage

/* hdl/regfile.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module regfile (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [4:0]            rd0_sel,
	input  logic [4:0]            rd1_sel,
	input  logic                  wr_en,
	input  logic [4:0]            wr_sel,
	input  logic [`MIPS_XLEN-1:0] wr_data,
	output logic [`MIPS_XLEN-1:0] rd0_data,
	output logic [`MIPS_XLEN-1:0] rd1_data
);
	logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];
	logic                  wr_live;	// a real write this cycle

	assign wr_live = wr_en && (wr_sel != 5'd0);	// r0 stays zero

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++)
				regs[i] <= (i == `MIPS_SP_REG) ? `MIPS_SP_INIT : '0;	// sp preset
		end else if (wr_live) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// write-first, same-cycle write shows up on the read ports
	assign rd0_data = (wr_live && wr_sel == rd0_sel) ? wr_data : regs[rd0_sel];
	assign rd1_data = (wr_live && wr_sel == rd1_sel) ? wr_data : regs[rd1_sel];

endmodule

/* include/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// datapath and address width
`define MIPS_XLEN 32

// general purpose register file size
`define MIPS_REG_COUNT 32

// first fetch address out of reset
`define MIPS_PC_INIT 32'h8002_0000

// stack pointer preset
`define MIPS_SP_INIT 32'h8012_0000

// register that receives the stack pointer preset
`define MIPS_SP_REG 29

`endif

/* list.f */
+incdir+include
hdl/mips_pkg.sv
hdl/ex_me_if.sv
hdl/regfile.sv
hdl/fetch_decode.sv
hdl/execute.sv
hdl/mem_writeback.sv
hdl/mips_core.sv
test/mips_checker.sv
test/tb_mips.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f list.f --top-module tb_mips -Mdir obj_dir -o tb_mips
output="$(./obj_dir/tb_mips)"
echo "$output"

if grep -qx "SIMULATION PASSED" <<< "$output"; then
	exit 0
fi
exit 1

/* test/mips_checker.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_checker #(
	parameter int prog_len = 200
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`MIPS_XLEN-1:0] program_words [prog_len],
	input  logic [`MIPS_XLEN-1:0] instr_addr,
	input  logic [`MIPS_XLEN-1:0] data_addr,
	input  logic [`MIPS_XLEN-1:0] data_out,
	input  logic                  data_rd_wr,
	output logic                  finished,
	output int                    failures
);
	localparam int cycle_limit = 4 * prog_len + 50;	// counted after reset
	localparam logic [`MIPS_XLEN-1:0] end_addr = `MIPS_PC_INIT + 32'(4 * (prog_len + 8));

	logic [`MIPS_XLEN-1:0] exp_addr [$];	// model stores in program order
	logic [`MIPS_XLEN-1:0] exp_data [$];
	bit                    exp_loaded [$];	// stored reg last written by a lw
	logic [`MIPS_XLEN-1:0] model_mem [logic [`MIPS_XLEN-1:0]];
	logic [`MIPS_XLEN-1:0] last_addr;
	bit                    reset_seen = 1'b0;
	bit                    running = 1'b0;
	int                    err_reset = 0;
	int                    err_fetch = 0;
	int                    err_store = 0;
	int                    err_load = 0;
	int                    err_count = 0;	// completeness and timeout
	int                    stores_seen = 0;
	int                    total_stores = 0;
	int                    load_use_pairs = 0;
	int                    cycles = 0;

	function automatic string status_text(input int errors);
		if (errors == 0)
			return "ok";
		return $sformatf("%0d errors", errors);
	endfunction

	// in-order reference run of the whole program
	task automatic run_model();
		logic [`MIPS_XLEN-1:0] regs [32];
		bit                    by_load [32];
		logic [`MIPS_XLEN-1:0] w;
		logic [`MIPS_XLEN-1:0] sx;
		logic [`MIPS_XLEN-1:0] a;
		logic [`MIPS_XLEN-1:0] val;
		logic [4:0]            rs;
		logic [4:0]            rt;
		logic [4:0]            dst;
		logic [4:0]            prev_dst;
		bit                    wr;
		bit                    ld;
		bit                    prev_ld;
		bit                    reads_rt;
		for (int r = 0; r < 32; r++) begin
			regs[r]    = '0;
			by_load[r] = 1'b0;
		end
		regs[`MIPS_SP_REG] = `MIPS_SP_INIT;
		prev_ld  = 1'b0;
		prev_dst = 5'd0;
		for (int i = 0; i < prog_len; i++) begin
			w  = program_words[i];
			rs = w[25:21];
			rt = w[20:16];
			sx = {{16{w[15]}}, w[15:0]};
			a  = regs[rs] + sx;	// addiu sum, or lw/sw address
			reads_rt = (w[31:26] == 6'h2b) ||
			           (w[31:26] == 6'h00 && (w[5:0] == 6'h21 || w[5:0] == 6'h23));
			// reader right behind a lw
			if (prev_ld && prev_dst != 5'd0 && (rs == prev_dst || (reads_rt && rt == prev_dst)))
				load_use_pairs++;
			wr  = 1'b0;
			ld  = 1'b0;
			dst = rt;
			val = a;
			case (w[31:26])
				6'h09: wr = 1'b1;	// addiu
				6'h23: begin	// lw
					val = model_mem.exists(a) ? model_mem[a] : a ^ 32'h3c3c_3c3c;
					wr  = 1'b1;
					ld  = 1'b1;
				end
				6'h2b: begin	// sw
					model_mem[a] = regs[rt];
					exp_addr.push_back(a);
					exp_data.push_back(regs[rt]);
					exp_loaded.push_back(by_load[rt]);
				end
				6'h00: begin
					dst = w[15:11];	// rd
					wr  = (w[5:0] == 6'h21) || (w[5:0] == 6'h23);	// sll is the nop
					val = (w[5:0] == 6'h23) ? regs[rs] - regs[rt] : regs[rs] + regs[rt];
				end
				default: ;	// unknown opcode, nop
			endcase
			if (wr && dst != 5'd0) begin	// r0 stays zero
				regs[dst]    = val;
				by_load[dst] = ld;
			end
			prev_ld  = ld;
			prev_dst = dst;
		end
	endtask

	task automatic check_reset_state(input string where);
		if (instr_addr !== `MIPS_PC_INIT) begin
			err_reset++;
			$display("[FAIL] instr_addr %s: expected %h got %h", where, `MIPS_PC_INIT, instr_addr);
		end
		if (data_rd_wr !== 1'b1) begin
			err_reset++;
			$display("[FAIL] data_rd_wr %s: expected 1 got %h", where, data_rd_wr);
		end
	endtask

	task automatic check_store();
		logic [`MIPS_XLEN-1:0] ea;
		logic [`MIPS_XLEN-1:0] ed;
		bit                    from_ld;
		bit                    bad;
		stores_seen++;
		if (exp_addr.size() == 0) begin
			err_count++;
			$display("store to %h seen after the model ran out of stores", data_addr);
			return;
		end
		ea      = exp_addr.pop_front();
		ed      = exp_data.pop_front();
		from_ld = exp_loaded.pop_front();
		bad     = 1'b0;
		if (data_addr !== ea) begin	// base is r29, so this also checks the sp preset
			$display("[FAIL] data_addr store %0d: expected %h got %h", stores_seen, ea, data_addr);
			bad = 1'b1;
		end
		if (data_out !== ed) begin
			$display("[FAIL] data_out store %0d: expected %h got %h", stores_seen, ed, data_out);
			bad = 1'b1;
		end
		if (bad && from_ld)
			err_load++;
		else if (bad)
			err_store++;
	endtask

	task automatic finish_run();
		if (exp_addr.size() != 0) begin
			err_count++;
			$display("%0d model stores never showed up on the data bus", exp_addr.size());
		end
		$display("test 2 fetch sequence: %s", status_text(err_fetch));
		$display("test 3 store stream: %s", status_text(err_store));
		$display("test 4 loads and load-use stall: %s, %0d load-use pairs",
		         status_text(err_load), load_use_pairs);
		$display("test 5 completeness: %s", status_text(err_count));
		failures = err_reset + err_fetch + err_store + err_load + err_count;
		$display("counts: %0d of %0d stores seen, %0d cycles, %0d errors",
		         stores_seen, total_stores, cycles, failures);
		finished = 1'b1;
	endtask

	// sample on the rising edge, before the DUT registers move
	always @(posedge clk) begin
		if (reset) begin
			finished = 1'b0;
			failures = 0;
			if (reset_seen)	// pc unknown before the first reset edge
				check_reset_state("during reset");
			reset_seen = 1'b1;
		end else if (!finished) begin
			if (!running) begin
				run_model();
				total_stores = exp_addr.size();
				check_reset_state("after reset");
				$display("test 1 reset state: %s", status_text(err_reset));
				last_addr = instr_addr;
				running   = 1'b1;
			end else if (instr_addr !== last_addr) begin	// no change is a stall
				if (instr_addr !== last_addr + 32'd4) begin
					err_fetch++;
					$display("[FAIL] instr_addr: expected %h got %h", last_addr + 32'd4, instr_addr);
				end
				last_addr = instr_addr;
			end
			if (data_rd_wr === 1'b0)
				check_store();
			cycles++;
			if (instr_addr >= end_addr)	// last program word has drained
				finish_run();
			else if (cycles >= cycle_limit) begin
				err_count++;
				$display("timeout: program did not finish within %0d cycles", cycle_limit);
				finish_run();
			end
		end
	end

endmodule

/* test/tb_mips.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_mips;
	localparam int prog_len = 200;	// random part, nops follow

	logic                  clk = 1'b0;
	logic                  reset = 1'b1;
	logic [`MIPS_XLEN-1:0] instr_in = '0;
	logic [`MIPS_XLEN-1:0] data_in = '0;
	logic [`MIPS_XLEN-1:0] instr_addr;
	logic [`MIPS_XLEN-1:0] data_addr;
	logic [`MIPS_XLEN-1:0] data_out;
	logic                  data_rd_wr;
	logic [`MIPS_XLEN-1:0] program_words [prog_len];	// instruction memory
	logic [`MIPS_XLEN-1:0] data_mem [logic [`MIPS_XLEN-1:0]];	// sparse, only written words
	logic [31:0]           seed = 32'h5ce2_6420;
	logic                  finished;
	int                    failures;

	always #4 clk = ~clk;	// 8 ns period

	mips_core mips_core_inst (
		.clk(clk), .reset(reset), .instr_in(instr_in), .data_in(data_in),
		.instr_addr(instr_addr), .data_addr(data_addr), .data_out(data_out),
		.data_rd_wr(data_rd_wr)
	);

	mips_checker #(.prog_len(prog_len)) checker_inst (
		.clk(clk), .reset(reset), .program_words(program_words),
		.instr_addr(instr_addr), .data_addr(data_addr), .data_out(data_out),
		.data_rd_wr(data_rd_wr), .finished(finished), .failures(failures)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// word at a fetch address, nop past the end of the program
	function automatic logic [`MIPS_XLEN-1:0] fetch_word(input logic [`MIPS_XLEN-1:0] addr);
		int idx;
		idx = int'((addr - `MIPS_PC_INIT) >> 2);
		if (idx >= 0 && idx < prog_len)
			return program_words[idx];
		return '0;
	endfunction

	task automatic build_program();
		logic [15:0] r;
		logic [15:0] imm;
		logic [15:0] off;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  last_ld;
		bit          after_ld;
		after_ld = 1'b0;
		last_ld  = 5'd0;
		for (int i = 0; i < prog_len; i++) begin
			seed = lcg_next(seed);
			r    = seed[31:16];	// upper bits, the low ones cycle fast
			seed = lcg_next(seed);
			imm  = seed[31:16];
			rs   = 5'(r[3:0]);	// sources r0..r15
			rt   = 5'(r[7:4]);
			rd   = 5'(r[11:8] % 4'd15) + 5'd1;	// dest r1..r15
			off  = {8'd0, imm[7:2], 2'b00};	// word aligned, below 256
			if (after_ld && r[15]) begin
				// store of the reg just loaded, forces the load-use stall
				program_words[i] = {mips_pkg::SW, 5'(`MIPS_SP_REG), last_ld, off};
				after_ld = 1'b0;
			end else begin
				after_ld = 1'b0;
				case (r[14:12])
					3'd0, 3'd1: program_words[i] = {mips_pkg::ADDIU, rs, rd, imm};
					3'd2: program_words[i] = {mips_pkg::SPECIAL, rs, rt, rd, 5'd0, mips_pkg::ADDU};
					3'd3: program_words[i] = {mips_pkg::SPECIAL, rs, rt, rd, 5'd0, mips_pkg::SUBU};
					3'd4: begin
						program_words[i] = {mips_pkg::LW, 5'(`MIPS_SP_REG), rd, off};
						after_ld = 1'b1;
						last_ld  = rd;
					end
					3'd5, 3'd6: program_words[i] = {mips_pkg::SW, 5'(`MIPS_SP_REG), rt, off};
					default: program_words[i] = '0;	// sll r0, r0, 0
				endcase
			end
		end
	endtask

	// bus side of the memories, addresses are stable mid-cycle
	always @(negedge clk) begin
		if (data_rd_wr === 1'b0)
			data_mem[data_addr] = data_out;	// store cycle
		instr_in = fetch_word(instr_addr);
		data_in  = data_mem.exists(data_addr) ? data_mem[data_addr]
		                                      : data_addr ^ 32'h3c3c_3c3c;	// fill pattern
	end

	initial begin
		build_program();
		repeat (4) @(negedge clk);
		reset = 1'b0;
		wait (finished);	// checker ends on program drain or its cycle limit
		if (failures == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
